// ==== Makefile ====
# Verilator build and run for the AXI4 read master testbench
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= axis2axi_rd_tb
FILELIST  ?= axis2axi_rd.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/10ps -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Test passed" $(LOG); then \
		echo "Simulation ended without a pass line, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== axis2axi_rd.f ====
verilog/axis2axi_rd_pkg.sv
verilog/axis2axi_rd_burst_split.sv
verilog/axis2axi_rd_ar_ctrl.sv
verilog/axis2axi_rd_stream_out.sv
verilog/axis2axi_rd.sv
verification/axis2axi_rd_tb.sv

// ==== verification/axis2axi_rd_tb.sv ====
// Self-checking testbench for axis2axi_rd with a one-burst-at-a-time AXI read memory.
// Memory data is the byte address XOR a fixed pattern. Random draws use a fixed seed.
`timescale 1ns/10ps

module axis2axi_rd_tb
   import axis2axi_rd_pkg::*;
();

   localparam logic [AXI_DATA_W-1:0] MEM_PATTERN = 32'h5A3C_96E1;
   localparam int N_RAND     = 24;
   localparam int DONE_LIMIT = 20000;

   logic                  clk_i        = 1'b0;
   logic                  rst_n_i      = 1'b0;
   rd_req_t               req_i        = '0;
   logic                  start_i      = 1'b0;
   logic                  m_arready_i  = 1'b0;
   r_beat_t               m_r_i        = '0;
   logic                  m_rvalid_i   = 1'b0;
   logic                  axis_ready_i = 1'b0;
   logic                  busy_o;
   ar_chan_t              m_ar_o;
   logic                  m_arvalid_o;
   logic                  m_rready_o;
   logic [AXI_DATA_W-1:0] axis_data_o;
   logic                  axis_valid_o;

   // Memory and sink knobs, changed only between requests
   int ready_pct    = 100;
   int gap_max      = 0;
   int ar_delay_max = 0;

   // Memory model state
   logic                  rd_active  = 1'b0;
   logic                  r_taken;
   logic [AXI_ADDR_W-1:0] beat_addr  = '0;
   int                    beats_left = 0;
   int                    r_gap      = 0;
   int                    ar_wait    = 0;

   // Stream ready seen in the previous cycle
   logic                  ready_prev = 1'b0;

   // Scoreboard
   ar_chan_t              exp_ar_q[$];
   logic [AXI_ADDR_W-1:0] exp_addr_q[$];
   ar_chan_t              exp_ar;
   logic [AXI_ADDR_W-1:0] exp_addr;
   rd_req_t               rand_reqs [N_RAND];
   integer                seed     = 45771;
   int                    checks   = 0;
   int                    errors   = 0;
   int                    requests = 0;

   always #20 clk_i = ~clk_i;

   axis2axi_rd dut0 (.*);

   function automatic int rand_below(input int n);
      int r;
      r = $random(seed);
      return (r & 32'h7fff_ffff) % n;
   endfunction

   // Expected stream word at a byte address
   function automatic logic [AXI_DATA_W-1:0] expected_word(input logic [AXI_ADDR_W-1:0] addr);
      return addr ^ MEM_PATTERN;
   endfunction

   // Appends the expected AR sequence of a request, returns the burst count
   function automatic int expected_bursts(input rd_req_t req);
      logic [AXI_ADDR_W-1:0] addr;
      int                    left;
      int                    room;
      int                    n;
      int                    count;
      ar_chan_t              ar;
      addr  = req.addr;
      left  = int'(req.words);
      count = 0;
      while (left > 0) begin
         room = 1024 - int'(addr[11:2]);
         n = room;
         if (n > 256) begin
            n = 256;
         end
         if (n > left) begin
            n = left;
         end
         ar.id    = '0;
         ar.addr  = addr;
         ar.len   = 8'(n - 1);
         ar.size  = 3'd2;
         ar.burst = 2'b01;
         ar.lock  = 2'b00;
         ar.cache = 4'b0010;
         ar.qos   = 4'd0;
         exp_ar_q.push_back(ar);
         addr  = addr + 32'(4 * n);
         left  = left - n;
         count = count + 1;
      end
      return count;
   endfunction

   function automatic rd_req_t make_req(input logic [AXI_ADDR_W-1:0] addr, input int words);
      rd_req_t r;
      r.addr  = addr;
      r.words = REQ_LEN_W'(words);
      return r;
   endfunction

   task automatic check_bit(input string what, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_ar(input ar_chan_t got, input ar_chan_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t ns: AR addr %h len %0d size %0d burst %0d cache %0d qos %0d,",
                  $time, got.addr, got.len, got.size, got.burst, got.cache, got.qos);
         $display("       expected addr %h len %0d size %0d burst %0d cache %0d qos %0d",
                  exp.addr, exp.len, exp.size, exp.burst, exp.cache, exp.qos);
      end
   endtask

   task automatic check_beat(input logic [AXI_DATA_W-1:0] got, input logic [AXI_DATA_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t ns: stream word %h, expected %h", $time, got, exp);
      end
   endtask

   task automatic abort_timeout(input string what);
      $display("Timeout at %0t ns while waiting for %s", $time, what);
      $display("Test failed");
      $finish;
   endtask

   // Memory model and stream sink, one AR at a time
   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         m_arready_i  <= 1'b0;
         m_rvalid_i   <= 1'b0;
         m_r_i        <= '0;
         axis_ready_i <= 1'b0;
         rd_active  = 1'b0;
         beats_left = 0;
         r_gap      = 0;
         ar_wait    = 0;
      end else begin
         axis_ready_i <= (rand_below(100) < ready_pct);
         r_taken = m_rvalid_i && m_rready_o;
         if (r_taken) begin
            m_rvalid_i <= 1'b0;
            beat_addr  = beat_addr + 32'd4;
            beats_left = beats_left - 1;
            r_gap      = rand_below(gap_max + 1);
            if (beats_left == 0) begin
               rd_active = 1'b0;
            end
         end
         if (m_arvalid_o && m_arready_i) begin
            m_arready_i <= 1'b0;
            rd_active  = 1'b1;
            beat_addr  = m_ar_o.addr;
            beats_left = int'(m_ar_o.len) + 1;
            ar_wait    = rand_below(ar_delay_max + 1);
            r_gap      = rand_below(gap_max + 1);
         end else if (m_arvalid_o && !rd_active) begin
            if (ar_wait == 0) begin
               m_arready_i <= 1'b1;
            end else begin
               ar_wait = ar_wait - 1;
            end
         end
         // Next beat after its gap
         if (rd_active && (!m_rvalid_i || r_taken)) begin
            if (r_gap > 0) begin
               r_gap = r_gap - 1;
            end else begin
               m_rvalid_i <= 1'b1;
               m_r_i.data <= beat_addr ^ MEM_PATTERN;
               m_r_i.last <= (beats_left == 1);
            end
         end
      end
   end

   // AR compare
   always @(negedge clk_i) begin
      if (rst_n_i && m_arvalid_o && m_arready_i) begin
         if (exp_ar_q.size() == 0) begin
            errors++;
            $display("Unexpected AR at %0t ns with address %h", $time, m_ar_o.addr);
         end else begin
            exp_ar = exp_ar_q.pop_front();
            check_ar(m_ar_o, exp_ar);
         end
      end
   end

   // Stream compare
   always @(negedge clk_i) begin
      if (rst_n_i && axis_valid_o && axis_ready_i) begin
         if (exp_addr_q.size() == 0) begin
            errors++;
            $display("Unexpected stream word at %0t ns, data %h", $time, axis_data_o);
         end else begin
            exp_addr = exp_addr_q.pop_front();
            check_beat(axis_data_o, expected_word(exp_addr));
         end
      end
   end

   // R channel ready trails the stream ready by one cycle
   always @(negedge clk_i) begin
      if (rst_n_i) begin
         check_bit("m_rready_o against axis_ready_i one cycle earlier", m_rready_o,
                   ready_prev);
      end
      ready_prev = axis_ready_i;
   end

   // Start pulse from idle with busy and AR timing checks
   task automatic start_request(input rd_req_t req);
      int i;
      int n;
      @(posedge clk_i);
      req_i   <= req;
      start_i <= 1'b1;
      n = expected_bursts(req);
      for (i = 0; i < int'(req.words); i++) begin
         exp_addr_q.push_back(req.addr + 32'(4 * i));
      end
      requests++;
      $display("Request %0d: address %h, %0d words, %0d bursts", requests, req.addr,
               req.words, n);
      @(negedge clk_i);
      check_bit("busy_o before start is taken", busy_o, 1'b0);
      @(posedge clk_i);
      start_i <= 1'b0;
      @(negedge clk_i);
      check_bit("busy_o one cycle after start", busy_o, 1'b1);
      check_bit("m_arvalid_o one cycle after start", m_arvalid_o, 1'b0);
      @(negedge clk_i);
      check_bit("m_arvalid_o two cycles after start", m_arvalid_o, 1'b1);
   endtask

   task automatic pulse_ignored_start(input rd_req_t req);
      check_bit("busy_o when extra start is pulsed", busy_o, 1'b1);
      @(posedge clk_i);
      req_i   <= req;
      start_i <= 1'b1;
      @(posedge clk_i);
      start_i <= 1'b0;
      @(negedge clk_i);
      check_bit("busy_o after ignored start", busy_o, 1'b1);
   endtask

   task automatic wait_words_left(input int left);
      int n;
      n = 0;
      while (exp_addr_q.size() > left) begin
         @(negedge clk_i);
         n++;
         if (n > DONE_LIMIT) begin
            abort_timeout("stream words to be accepted");
         end
      end
   endtask

   task automatic wait_request_done();
      int n;
      n = 0;
      while (busy_o !== 1'b0) begin
         @(negedge clk_i);
         n++;
         if (n > DONE_LIMIT) begin
            abort_timeout("busy_o to fall");
         end
      end
      // Busy drops only once the memory has returned every beat
      check_bit("memory idle when busy_o falls", ~rd_active, 1'b1);
      check_bit("all bursts issued when busy_o falls", exp_ar_q.size() == 0, 1'b1);
      wait_words_left(0);
      // Quiet gap catches stray AR or stream words
      repeat (8) @(negedge clk_i);
   endtask

   task automatic run_request(input rd_req_t req);
      start_request(req);
      wait_request_done();
   endtask

   initial begin
      int i;
      // Random requests drawn before the memory model starts drawing
      for (i = 0; i < N_RAND; i++) begin
         rand_reqs[i].addr  = {12'h000, 18'(rand_below(1 << 18)), 2'b00};
         rand_reqs[i].words = REQ_LEN_W'(1 + rand_below(511));
      end
      repeat (4) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      check_bit("m_arvalid_o after reset", m_arvalid_o, 1'b0);
      check_bit("m_rready_o after reset", m_rready_o, 1'b0);
      check_bit("busy_o after reset", busy_o, 1'b0);
      check_bit("axis_valid_o after reset", axis_valid_o, 1'b0);
      repeat (2) @(negedge clk_i);

      // Single burst inside one page
      run_request(make_req(32'h0000_1000, 16));
      // Crosses the 4 KB boundary after four words
      ar_delay_max = 2;
      gap_max      = 1;
      run_request(make_req(32'h0000_2FF0, 10));
      // Longest request, cut by page and by 256 beats
      ar_delay_max = 1;
      gap_max      = 0;
      run_request(make_req(32'h0000_4F00, 511));
      // Stream back-pressure
      ready_pct    = 50;
      gap_max      = 2;
      ar_delay_max = 3;
      run_request(make_req(32'h0000_8A00, 300));

      // Starts while busy go nowhere
      ready_pct    = 80;
      gap_max      = 1;
      ar_delay_max = 1;
      start_request(make_req(32'h0000_0F80, 64));
      pulse_ignored_start(make_req(32'h0004_0000, 8));
      wait_words_left(20);
      pulse_ignored_start(make_req(32'h0005_0000, 8));
      wait_request_done();
      run_request(make_req(32'h0000_C000, 24));

      // Random requests with AR stalls, R gaps and back-pressure
      ready_pct    = 70;
      gap_max      = 3;
      ar_delay_max = 6;
      for (i = 0; i < N_RAND; i++) begin
         run_request(rand_reqs[i]);
      end

      check_bit("expected AR list drained", exp_ar_q.size() == 0, 1'b1);
      $display("Summary: %0d requests, %0d checks, %0d errors", requests, checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== verilog/axis2axi_rd.sv ====
// AXI4 read master that streams a word-aligned read request as 32-bit words.
// Requests of 1 to 511 words; rresp is ignored.
`timescale 1ns/10ps

module axis2axi_rd
   import axis2axi_rd_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,

   // Request
   input  rd_req_t               req_i,
   input  logic                  start_i,
   output logic                  busy_o,

   // AXI read address
   output ar_chan_t              m_ar_o,
   output logic                  m_arvalid_o,
   input  logic                  m_arready_i,

   // AXI read data
   input  r_beat_t               m_r_i,
   input  logic                  m_rvalid_i,
   output logic                  m_rready_o,

   // Stream out
   output logic [AXI_DATA_W-1:0] axis_data_o,
   output logic                  axis_valid_o,
   input  logic                  axis_ready_i
);

   burst_cmd_t cmd;
   logic       cmd_strobe;
   logic       burst_idle;
   logic       last_done;

   axis2axi_rd_burst_split split0 (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_i       (req_i),
      .start_i     (start_i),
      .burst_idle_i(burst_idle),
      .cmd_o       (cmd),
      .cmd_strobe_o(cmd_strobe),
      .busy_o      (busy_o)
   );

   axis2axi_rd_ar_ctrl ar0 (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cmd_i       (cmd),
      .cmd_strobe_i(cmd_strobe),
      .m_arready_i (m_arready_i),
      .last_done_i (last_done),
      .m_ar_o      (m_ar_o),
      .m_arvalid_o (m_arvalid_o),
      .burst_idle_o(burst_idle)
   );

   axis2axi_rd_stream_out out0 (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .m_r_i       (m_r_i),
      .m_rvalid_i  (m_rvalid_i),
      .axis_ready_i(axis_ready_i),
      .m_rready_o  (m_rready_o),
      .axis_data_o (axis_data_o),
      .axis_valid_o(axis_valid_o),
      .last_done_o (last_done)
   );

endmodule

// ==== verilog/axis2axi_rd_ar_ctrl.sv ====
// AR channel controller, one burst at a time.
// burst_idle_o also rises in the cycle the final beat of a burst is accepted.
`timescale 1ns/10ps

module axis2axi_rd_ar_ctrl
   import axis2axi_rd_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  burst_cmd_t cmd_i,
   input  logic       cmd_strobe_i,
   input  logic       m_arready_i,
   input  logic       last_done_i,
   output ar_chan_t   m_ar_o,
   output logic       m_arvalid_o,
   output logic       burst_idle_o
);

   logic [1:0] state;
   logic       load;

   // New command only taken when idle
   assign load = (state == ST_IDLE) & cmd_strobe_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state       <= ST_IDLE;
         m_arvalid_o <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (cmd_strobe_i) begin
                  state       <= ST_ADDR;
                  m_arvalid_o <= 1'b1;
               end
            end

            ST_ADDR: begin
               // Hold the address until the slave takes it
               if (m_arready_i) begin
                  state       <= ST_DATA;
                  m_arvalid_o <= 1'b0;
               end
            end

            ST_DATA: begin
               if (last_done_i) begin
                  state <= ST_IDLE;
               end
            end

            default: begin
               state       <= ST_IDLE;
               m_arvalid_o <= 1'b0;
            end
         endcase
      end
   end

   // AR payload with the fixed fields
   always_ff @(posedge clk_i) begin
      if (load) begin
         m_ar_o.id    <= '0;
         m_ar_o.addr  <= cmd_i.addr;
         m_ar_o.len   <= cmd_i.len;
         m_ar_o.size  <= AR_SIZE;
         m_ar_o.burst <= AR_BURST;
         m_ar_o.lock  <= AR_LOCK;
         m_ar_o.cache <= AR_CACHE;
         m_ar_o.qos   <= AR_QOS;
      end
   end

   // Early idle lets the splitter cut the next burst during the last beat
   assign burst_idle_o = (state == ST_IDLE) | ((state == ST_DATA) & last_done_i);

   // AXI rule on the address channel
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (m_arvalid_o && !m_arready_i) |=> (m_arvalid_o && $stable(m_ar_o)))
      else $error("AR payload changed before handshake");

endmodule

// ==== verilog/axis2axi_rd_burst_split.sv ====
// Splits a request into INCR bursts of at most 256 beats that stay in one 4 KB page.
// A start with zero words, or a start while busy, is ignored.
`timescale 1ns/10ps

module axis2axi_rd_burst_split
   import axis2axi_rd_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  rd_req_t    req_i,
   input  logic       start_i,
   input  logic       burst_idle_i,
   output burst_cmd_t cmd_o,
   output logic       cmd_strobe_o,
   output logic       busy_o
);

   logic [AXI_ADDR_W-1:0]      next_addr;
   logic [REQ_LEN_W-1:0]       remain;
   logic                       busy_q;
   logic                       idle_q;
   logic                       idle_rise;
   logic                       accept;
   logic                       issue;
   logic [AXI_ADDR_W-1:0]      src_addr;
   logic [REQ_LEN_W-1:0]       src_words;
   logic [PAGE_WORDS_LOG2-1:0] word_idx;
   logic [PAGE_ROOM_W-1:0]     page_room;
   logic [PAGE_ROOM_W-1:0]     beats;
   logic [REQ_LEN_W-1:0]       burst_words;

   // Previous burst finished
   assign idle_rise = burst_idle_i & ~idle_q;

   assign accept = start_i & ~busy_q & (req_i.words != '0);
   assign issue  = accept | (busy_q & idle_rise & (remain != '0));

   assign busy_o = busy_q;

   // Next burst from either the new request or what is left of it
   always_comb begin
      src_addr  = accept ? req_i.addr : next_addr;
      src_words = accept ? req_i.words : remain;
      word_idx  = src_addr[PAGE_BYTES_LOG2-1:BEAT_BYTES_LOG2];

      // Words left before the page boundary, 1 to 1024
      page_room = PAGE_ROOM_W'(1 << PAGE_WORDS_LOG2) - PAGE_ROOM_W'(word_idx);

      beats = page_room;
      if (beats > PAGE_ROOM_W'(MAX_BURST_BEATS)) begin
         beats = PAGE_ROOM_W'(MAX_BURST_BEATS);
      end
      if (beats > PAGE_ROOM_W'(src_words)) begin
         beats = PAGE_ROOM_W'(src_words);
      end
      burst_words = REQ_LEN_W'(beats);
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q       <= 1'b0;
         cmd_strobe_o <= 1'b0;
         idle_q       <= 1'b1;
         remain       <= '0;
      end else begin
         idle_q       <= burst_idle_i;
         cmd_strobe_o <= issue;
         if (issue) begin
            busy_q <= 1'b1;
            remain <= src_words - burst_words;
         end else if (busy_q && idle_rise) begin
            // Last burst done and nothing left
            busy_q <= 1'b0;
         end
      end
   end

   // Command and running address
   always_ff @(posedge clk_i) begin
      if (issue) begin
         cmd_o.addr <= src_addr;
         cmd_o.len  <= AXI_LEN_W'(burst_words - 1'b1);
         next_addr  <= src_addr + (AXI_ADDR_W'(burst_words) << BEAT_BYTES_LOG2);
      end
   end

   // Burst end stays inside the page of its start
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cmd_strobe_o |->
         ({1'b0, cmd_o.addr[PAGE_BYTES_LOG2-1:BEAT_BYTES_LOG2]}
          + PAGE_ROOM_W'(cmd_o.len) + PAGE_ROOM_W'(1))
         <= PAGE_ROOM_W'(1 << PAGE_WORDS_LOG2))
      else $error("burst crosses a 4 KB page");

   // The address controller must be free when a command arrives
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cmd_strobe_o |-> burst_idle_i)
      else $error("burst command issued while a burst is in flight");

endmodule

// ==== verilog/axis2axi_rd_pkg.sv ====
// Shared widths, AXI constant fields and channel structs for the read master.
// Only 4-byte beats and word-aligned addresses are supported.
package axis2axi_rd_pkg;

   // Bus widths
   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 32;
   localparam int AXI_LEN_W  = 8;
   localparam int AXI_ID_W   = 1;

   // One extra bit so a request can span two full bursts minus one word
   localparam int REQ_LEN_W = AXI_LEN_W + 1;

   // Beat and page geometry
   localparam int BEAT_BYTES_LOG2 = 2;
   localparam int PAGE_BYTES_LOG2 = 12;
   localparam int PAGE_WORDS_LOG2 = PAGE_BYTES_LOG2 - BEAT_BYTES_LOG2;
   localparam int PAGE_ROOM_W     = PAGE_WORDS_LOG2 + 1;
   localparam int MAX_BURST_BEATS = 1 << AXI_LEN_W;

   // Constant AR fields
   localparam logic [2:0] AR_SIZE  = 3'(BEAT_BYTES_LOG2);
   localparam logic [1:0] AR_BURST = 2'd1;  // INCR
   localparam logic [1:0] AR_LOCK  = 2'd0;
   localparam logic [3:0] AR_CACHE = 4'd2;  // normal, modifiable
   localparam logic [3:0] AR_QOS   = 4'd0;

   // Address channel FSM encoding
   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_ADDR = 2'd1;
   localparam logic [1:0] ST_DATA = 2'd2;

   // Read request, length in words
   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;
      logic [REQ_LEN_W-1:0]  words;
   } rd_req_t;

   // One burst, len holds beats minus one
   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;
      logic [AXI_LEN_W-1:0]  len;
   } burst_cmd_t;

   // Full AR payload
   typedef struct packed {
      logic [AXI_ID_W-1:0]   id;
      logic [AXI_ADDR_W-1:0] addr;
      logic [AXI_LEN_W-1:0]  len;
      logic [2:0]            size;
      logic [1:0]            burst;
      logic [1:0]            lock;
      logic [3:0]            cache;
      logic [3:0]            qos;
   } ar_chan_t;

   // Returned beat, rresp is not carried
   typedef struct packed {
      logic [AXI_DATA_W-1:0] data;
      logic                  last;
   } r_beat_t;

endpackage

// ==== verilog/axis2axi_rd_stream_out.sv ====
// R channel to stream stage. rready is axis_ready_i delayed one cycle, and the
// beat accepted in that lag cycle is held until the stream consumes it.
`timescale 1ns/10ps

module axis2axi_rd_stream_out
   import axis2axi_rd_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  r_beat_t               m_r_i,
   input  logic                  m_rvalid_i,
   input  logic                  axis_ready_i,
   output logic                  m_rready_o,
   output logic [AXI_DATA_W-1:0] axis_data_o,
   output logic                  axis_valid_o,
   output logic                  last_done_o
);

   logic [AXI_DATA_W-1:0] hold_data;
   logic                  hold_valid;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         m_rready_o <= 1'b0;
         hold_valid <= 1'b0;
      end else begin
         m_rready_o <= axis_ready_i;
         if (m_rready_o) begin
            hold_valid <= m_rvalid_i;
         end
      end
   end

   // Copy of the live beat while the R channel is open
   always_ff @(posedge clk_i) begin
      if (m_rready_o) begin
         hold_data <= m_r_i.data;
      end
   end

   // Live beat when open, held beat while stalled
   assign axis_data_o  = m_rready_o ? m_r_i.data : hold_data;
   assign axis_valid_o = m_rready_o ? m_rvalid_i : hold_valid;

   assign last_done_o = m_rvalid_i & m_rready_o & m_r_i.last;

   // A stalled beat stays on the stream
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (axis_valid_o && !axis_ready_i) |=>
         (axis_valid_o && (axis_data_o == $past(axis_data_o))))
      else $error("stream beat changed while stalled");

endmodule
